// ==== logic/protection_params.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// size macros for the over-range protection
// block: channel count, sample width and
// register address width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PROTECTION_PARAMS_SVH
`define PROTECTION_PARAMS_SVH

// number of protected converter channels
`define PROT_CHANNELS 4

// signed sample and threshold width in bits
`define PROT_DATA_WIDTH 16

// register port address width, enough for 16 thresholds plus mask and clear
`define PROT_ADDRESS_WIDTH 5

`endif

// ==== logic/protection_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the protection block:
// samples, channel masks, addresses and
// threshold or channel indices
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "protection_params.svh"

package protection_pkg;

    // a signed converter sample, also used for every threshold
    typedef logic signed [`PROT_DATA_WIDTH-1:0] sample_t;

    // one bit per channel for trips, latching mask, clears and status
    typedef logic [`PROT_CHANNELS-1:0] channel_mask_t;

    // address on the register write port
    typedef logic [`PROT_ADDRESS_WIDTH-1:0] register_address_t;

    // selects one of the four thresholds inside a channel
    typedef logic [1:0] threshold_index_t;

    // number of a channel, 0 to 3
    typedef logic [1:0] channel_index_t;

endpackage

`default_nettype wire

// ==== logic/threshold_comparator.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window comparator of one channel with
// four thresholds, hysteresis and latching
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module threshold_comparator (
    input wire clock,
    input wire reset,
    input wire threshold_write,
    input wire protection_pkg::threshold_index_t threshold_select,
    input wire protection_pkg::sample_t threshold_value,
    input wire sample_valid,
    input wire protection_pkg::sample_t sample,
    input wire latching_mode,
    input wire clear_latch,
    output logic trip_high,
    output logic trip_low
);

    import protection_pkg::*;

    // threshold map inside the channel
    //   0  low trip, a sample below it sets trip_low
    //   1  low release, a sample above it clears trip_low
    //   2  high release, a sample below it clears trip_high
    //   3  high trip, a sample above it sets trip_high
    // the gap between trip and release forms the hysteresis band
    sample_t thresholds [4];

    // set by any trip while in latching mode, held until a clear pulse
    logic latched;

    // the latch only holds trips and blocks writes while latching is enabled
    logic latch_hold;

    // an incoming threshold write is taken only when the channel is not latched
    logic write_accept;

    assign latch_hold = latching_mode && latched;
    assign write_accept = threshold_write && !latch_hold;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 4; i++) begin
                thresholds[i] <= '0;
            end
            trip_high <= 1'b0;
            trip_low <= 1'b0;
            latched <= 1'b0;
        end else begin
            // a clear pulse drops the latch, and so does leaving latching mode
            // a trip set further down in this same cycle still wins
            if (clear_latch || !latching_mode) begin
                latched <= 1'b0;
            end

            if (write_accept) begin
                // new thresholds invalidate the old trip state of the channel
                // so both trips restart from 0, any sample in this cycle is dropped
                thresholds[threshold_select] <= threshold_value;
                trip_high <= 1'b0;
                trip_low <= 1'b0;
            end else if (sample_valid) begin
                // low side, signed compare against trip and release levels
                if (sample < thresholds[0]) begin
                    trip_low <= 1'b1;
                    if (latching_mode) begin
                        latched <= 1'b1;
                    end
                end else if (sample > thresholds[1] && !latch_hold) begin
                    trip_low <= 1'b0;
                end

                // high side, samples in the band keep the previous state
                if (sample > thresholds[3]) begin
                    trip_high <= 1'b1;
                    if (latching_mode) begin
                        latched <= 1'b1;
                    end
                end else if (sample < thresholds[2] && !latch_hold) begin
                    trip_high <= 1'b0;
                end
            end
            // a write refused while latched is simply lost
        end
    end

endmodule

`default_nettype wire

// ==== logic/protection_registers.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register write decoder: latching mask,
// threshold write pulses and clear pulses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "protection_params.svh"

module protection_registers (
    input wire clock,
    input wire reset,
    input wire write_strobe,
    input wire protection_pkg::register_address_t write_address,
    input wire protection_pkg::sample_t write_data,
    output protection_pkg::channel_mask_t threshold_write,
    output protection_pkg::threshold_index_t threshold_select,
    output protection_pkg::sample_t threshold_value,
    output protection_pkg::channel_mask_t latching_mask,
    output protection_pkg::channel_mask_t clear_latch
);

    import protection_pkg::*;

    // thresholds occupy 4 words per channel starting at address 0
    localparam int THRESHOLD_WORDS = 4 * `PROT_CHANNELS;

    // control words directly above the threshold block
    localparam register_address_t MASK_ADDRESS = register_address_t'(16);
    localparam register_address_t CLEAR_ADDRESS = register_address_t'(17);

    // address split for a threshold word, channel in the upper bits
    channel_index_t write_channel;
    threshold_index_t write_index;

    // one decode flag per kind of write, any other address falls through
    logic threshold_hit;
    logic mask_hit;
    logic clear_hit;

    // only the low channel bits of the data word matter for mask and clear
    channel_mask_t write_bits;

    assign write_channel = write_address[3:2];
    assign write_index = write_address[1:0];
    assign write_bits = write_data[`PROT_CHANNELS-1:0];

    assign threshold_hit = write_strobe && (int'(write_address) < THRESHOLD_WORDS);
    assign mask_hit = write_strobe && (write_address == MASK_ADDRESS);
    assign clear_hit = write_strobe && (write_address == CLEAR_ADDRESS);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            threshold_write <= '0;
            latching_mask <= '0;
            clear_latch <= '0;
        end else begin
            // pulses last a single cycle and return to 0 without a strobe
            threshold_write <= '0;
            clear_latch <= '0;

            if (threshold_hit) begin
                threshold_write <= channel_mask_t'(1) << write_channel;
            end

            if (mask_hit) begin
                latching_mask <= write_bits;
            end

            if (clear_hit) begin
                clear_latch <= write_bits;
            end
        end
    end

    // threshold payload travels next to the one-hot pulse
    // comparators only look at it while their pulse bit is set
    always_ff @(posedge clock) begin
        if (threshold_hit) begin
            threshold_select <= write_index;
            threshold_value <= write_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fault_collector.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fault collector: registered fault,
// sticky status and first-fault capture
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "protection_params.svh"

module fault_collector (
    input wire clock,
    input wire reset,
    input wire protection_pkg::channel_mask_t trip_high,
    input wire protection_pkg::channel_mask_t trip_low,
    input wire protection_pkg::channel_mask_t clear,
    output logic fault,
    output protection_pkg::channel_mask_t status_high,
    output protection_pkg::channel_mask_t status_low,
    output logic first_fault_valid,
    output protection_pkg::channel_index_t first_fault_channel
);

    import protection_pkg::*;

    // a channel counts as tripped when either side of its window is active
    channel_mask_t channel_trips;

    // lowest numbered channel that is currently tripped
    channel_index_t lowest_channel;

    // a clear with every bit set also releases the first-fault capture
    logic full_clear;

    assign channel_trips = trip_high | trip_low;
    assign full_clear = &clear;

    // priority encoder, scanning down so that the lowest index is left last
    always_comb begin
        lowest_channel = '0;
        for (int i = `PROT_CHANNELS - 1; i >= 0; i--) begin
            if (channel_trips[i]) begin
                lowest_channel = channel_index_t'(i);
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            fault <= 1'b0;
            status_high <= '0;
            status_low <= '0;
            first_fault_valid <= 1'b0;
        end else begin
            // the switching disable follows any trip one cycle later
            fault <= |channel_trips;

            // sticky bits, a trip present in the clear cycle sets them again
            status_high <= (status_high & ~clear) | trip_high;
            status_low <= (status_low & ~clear) | trip_low;

            if (full_clear) begin
                first_fault_valid <= 1'b0;
            end else if (!first_fault_valid && (|channel_trips)) begin
                first_fault_valid <= 1'b1;
            end
        end
    end

    // the channel number is frozen once the capture is valid
    always_ff @(posedge clock) begin
        if (!full_clear && !first_fault_valid && (|channel_trips)) begin
            first_fault_channel <= lowest_channel;
        end
    end

endmodule

`default_nettype wire

// ==== logic/protection_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protection top level: register decoder,
// per-channel comparators, fault collector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "protection_params.svh"

module protection_top (
    input wire clock,
    input wire reset,
    input wire sample_valid,
    input wire protection_pkg::sample_t sample_0,
    input wire protection_pkg::sample_t sample_1,
    input wire protection_pkg::sample_t sample_2,
    input wire protection_pkg::sample_t sample_3,
    input wire write_strobe,
    input wire protection_pkg::register_address_t write_address,
    input wire protection_pkg::sample_t write_data,
    output wire protection_pkg::channel_mask_t trip_high,
    output wire protection_pkg::channel_mask_t trip_low,
    output wire fault,
    output wire protection_pkg::channel_mask_t status_high,
    output wire protection_pkg::channel_mask_t status_low,
    output wire first_fault_valid,
    output wire protection_pkg::channel_index_t first_fault_channel
);

    import protection_pkg::*;

    // decoded register writes, one cycle after the strobe
    channel_mask_t threshold_write;
    threshold_index_t threshold_select;
    sample_t threshold_value;
    channel_mask_t latching_mask;
    channel_mask_t clear_latch;

    // samples gathered so the generate loop can index them
    sample_t samples [`PROT_CHANNELS];

    assign samples[0] = sample_0;
    assign samples[1] = sample_1;
    assign samples[2] = sample_2;
    assign samples[3] = sample_3;

    protection_registers registers (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .threshold_write(threshold_write),
        .threshold_select(threshold_select),
        .threshold_value(threshold_value),
        .latching_mask(latching_mask),
        .clear_latch(clear_latch)
    );

    // every channel sees the shared threshold payload but only its own pulse bit
    for (genvar channel = 0; channel < `PROT_CHANNELS; channel++) begin : g_channel
        threshold_comparator comparator (
            .clock(clock),
            .reset(reset),
            .threshold_write(threshold_write[channel]),
            .threshold_select(threshold_select),
            .threshold_value(threshold_value),
            .sample_valid(sample_valid),
            .sample(samples[channel]),
            .latching_mode(latching_mask[channel]),
            .clear_latch(clear_latch[channel]),
            .trip_high(trip_high[channel]),
            .trip_low(trip_low[channel])
        );
    end

    // the clear pulses also reset the sticky status of the same channels
    fault_collector collector (
        .clock(clock),
        .reset(reset),
        .trip_high(trip_high),
        .trip_low(trip_low),
        .clear(clear_latch),
        .fault(fault),
        .status_high(status_high),
        .status_low(status_low),
        .first_fault_valid(first_fault_valid),
        .first_fault_channel(first_fault_channel)
    );

endmodule

`default_nettype wire

// ==== test/protection_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench of protection_top with
// a reference model, compare tasks, watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "protection_params.svh"

module protection_tb;

    import protection_pkg::*;

    // reset plus about 110 writes and 230 sample strobes of 3 cycles each and some idle gaps
    localparam int TEST_CYCLES = 8 + 3 * 110 + 3 * 230 + 40;
    localparam int WATCHDOG_NS = 2 * 10 * TEST_CYCLES;

    logic clock;
    logic reset;
    logic sample_valid;
    sample_t sample_0;
    sample_t sample_1;
    sample_t sample_2;
    sample_t sample_3;
    logic write_strobe;
    register_address_t write_address;
    sample_t write_data;
    channel_mask_t trip_high;
    channel_mask_t trip_low;
    logic fault;
    channel_mask_t status_high;
    channel_mask_t status_low;
    logic first_fault_valid;
    channel_index_t first_fault_channel;

    int error_count;

    // reference model state that follows the register map and comparator rules
    sample_t model_threshold [`PROT_CHANNELS][4];
    channel_mask_t model_trip_high;
    channel_mask_t model_trip_low;
    channel_mask_t model_latched;
    channel_mask_t model_mask;
    channel_mask_t model_status_high;
    channel_mask_t model_status_low;
    logic model_ff_valid;
    channel_index_t model_ff_channel;

    protection_top UUT (
        .clock(clock),
        .reset(reset),
        .sample_valid(sample_valid),
        .sample_0(sample_0),
        .sample_1(sample_1),
        .sample_2(sample_2),
        .sample_3(sample_3),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .trip_high(trip_high),
        .trip_low(trip_low),
        .fault(fault),
        .status_high(status_high),
        .status_low(status_low),
        .first_fault_valid(first_fault_valid),
        .first_fault_channel(first_fault_channel)
    );

    always #5 clock = ~clock;

    task automatic check_mask(input string name, input channel_mask_t actual,
                              input channel_mask_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s got %b expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic check_channel(input string name, input channel_index_t actual,
                                 input channel_index_t expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic check_trips();
        check_mask("trip_high", trip_high, model_trip_high);
        check_mask("trip_low", trip_low, model_trip_low);
    endtask

    // the collector outputs lag the trips by one cycle, so call this once trips are stable
    task automatic check_outputs();
        check_trips();
        check_bit("fault", fault, |(model_trip_high | model_trip_low));
        check_mask("status_high", status_high, model_status_high);
        check_mask("status_low", status_low, model_status_low);
        check_bit("first_fault_valid", first_fault_valid, model_ff_valid);
        if (model_ff_valid) begin
            check_channel("first_fault_channel", first_fault_channel, model_ff_channel);
        end
    endtask

    // applies one strobed sample to one channel under the window and latch rules
    task automatic model_sample_channel(input int ch, input sample_t value);
        logic hold;
        hold = model_mask[ch] && model_latched[ch];
        if (value < model_threshold[ch][0]) begin
            model_trip_low[ch] = 1'b1;
            model_latched[ch] = model_latched[ch] | model_mask[ch];
        end else if (value > model_threshold[ch][1] && !hold) begin
            model_trip_low[ch] = 1'b0;
        end
        if (value > model_threshold[ch][3]) begin
            model_trip_high[ch] = 1'b1;
            model_latched[ch] = model_latched[ch] | model_mask[ch];
        end else if (value < model_threshold[ch][2] && !hold) begin
            model_trip_high[ch] = 1'b0;
        end
    endtask

    // updates the sticky status and captures the first tripping channel where the lowest
    // number wins a tie
    task automatic model_collect();
        channel_mask_t trips;
        logic found;
        trips = model_trip_high | model_trip_low;
        found = 1'b0;
        model_status_high = model_status_high | model_trip_high;
        model_status_low = model_status_low | model_trip_low;
        if (!model_ff_valid) begin
            for (int ch = 0; ch < `PROT_CHANNELS; ch++) begin
                if (trips[ch] && !found) begin
                    found = 1'b1;
                    model_ff_channel = channel_index_t'(ch);
                end
            end
            model_ff_valid = found;
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #1;
        end
    endtask

    // the decoded pulse follows the strobe by one edge and the comparator loads one edge later
    task automatic write_register(input int address, input int data);
        @(posedge clock);
        #1;
        write_strobe = 1'b1;
        write_address = register_address_t'(address);
        write_data = sample_t'(data);
        @(posedge clock);
        #1;
        write_strobe = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic write_threshold(input int ch, input int index, input int value);
        write_register(4 * ch + index, value);
        // a latched channel drops the write and an accepted one zeroes both trips
        if (!(model_mask[ch] && model_latched[ch])) begin
            model_threshold[ch][index] = sample_t'(value);
            model_trip_high[ch] = 1'b0;
            model_trip_low[ch] = 1'b0;
        end
    endtask

    task automatic write_mask(input channel_mask_t mask);
        write_register(16, int'(mask));
        model_mask = mask;
        model_latched = model_latched & mask;
    endtask

    task automatic write_clear(input channel_mask_t bits);
        write_register(17, int'(bits));
        model_status_high = model_status_high & ~bits;
        model_status_low = model_status_low & ~bits;
        model_latched = model_latched & ~bits;
        if (&bits) begin
            model_ff_valid = 1'b0;
        end
        // trips still present in the clear cycle set the status again
        model_collect();
    endtask

    // trips are checked one edge after the strobe and the collector outputs one edge later
    task automatic apply_samples(input int s0, input int s1, input int s2, input int s3);
        sample_t values [4];
        values[0] = sample_t'(s0);
        values[1] = sample_t'(s1);
        values[2] = sample_t'(s2);
        values[3] = sample_t'(s3);
        @(posedge clock);
        #1;
        sample_0 = values[0];
        sample_1 = values[1];
        sample_2 = values[2];
        sample_3 = values[3];
        sample_valid = 1'b1;
        for (int ch = 0; ch < `PROT_CHANNELS; ch++) begin
            model_sample_channel(ch, values[ch]);
        end
        @(posedge clock);
        #1;
        sample_valid = 1'b0;
        check_trips();
        model_collect();
        @(posedge clock);
        #1;
        check_outputs();
    endtask

    // symmetric windows that widen by 100 per channel
    task automatic load_default_thresholds();
        int base;
        for (int ch = 0; ch < `PROT_CHANNELS; ch++) begin
            base = 1000 + 100 * ch;
            write_threshold(ch, 0, -base);
            write_threshold(ch, 1, -(base - 200));
            write_threshold(ch, 2, base - 200);
            write_threshold(ch, 3, base);
        end
    endtask

    task automatic random_thresholds(input int ch);
        sample_t values [4];
        sample_t swap;
        for (int i = 0; i < 4; i++) begin
            values[i] = sample_t'($urandom);
        end
        // ascending order keeps low trip <= low release <= high release <= high trip
        for (int pass = 0; pass < 3; pass++) begin
            for (int i = 0; i < 3 - pass; i++) begin
                if (values[i] > values[i + 1]) begin
                    swap = values[i];
                    values[i] = values[i + 1];
                    values[i + 1] = swap;
                end
            end
        end
        for (int i = 0; i < 4; i++) begin
            write_threshold(ch, i, int'(values[i]));
        end
    endtask

    task automatic test_reset_and_idle();
        check_outputs();
        load_default_thresholds();
        apply_samples(0, 100, -100, 500);
    endtask

    task automatic hysteresis_step(input int value, input logic low, input logic high);
        apply_samples(value, 0, 0, 0);
        check_bit("trip_low[0]", trip_low[0], low);
        check_bit("trip_high[0]", trip_high[0], high);
    endtask

    // channel 0 window is -1000 / -800 / 800 / 1000
    task automatic test_hysteresis();
        hysteresis_step(-1100, 1'b1, 1'b0);
        hysteresis_step(-900, 1'b1, 1'b0);
        hysteresis_step(-700, 1'b0, 1'b0);
        hysteresis_step(1100, 1'b0, 1'b1);
        hysteresis_step(900, 1'b0, 1'b1);
        hysteresis_step(700, 1'b0, 1'b0);
    endtask

    task automatic test_random_normal();
        for (int round = 0; round < 4; round++) begin
            for (int ch = 0; ch < `PROT_CHANNELS; ch++) begin
                random_thresholds(ch);
            end
            repeat (50) begin
                apply_samples(int'(sample_t'($urandom)), int'(sample_t'($urandom)),
                              int'(sample_t'($urandom)), int'(sample_t'($urandom)));
            end
        end
    endtask

    // channel 1 latches with its low trip at -1100 and its release above -900
    task automatic test_latching();
        load_default_thresholds();
        apply_samples(0, 0, 0, 0);
        write_mask(4'b0010);
        apply_samples(0, -1500, 0, 0);
        apply_samples(0, 0, 0, 0);
        check_bit("trip_low[1]", trip_low[1], 1'b1);
        // the write is refused while latched and the trip survives the attempt
        write_threshold(1, 0, -2000);
        check_trips();
        write_clear(4'b0010);
        check_trips();
        apply_samples(0, 0, 0, 0);
        check_bit("trip_low[1]", trip_low[1], 1'b0);
        // the old -1100 level still trips, so the refused write is gone
        apply_samples(0, -1500, 0, 0);
        check_bit("trip_low[1]", trip_low[1], 1'b1);
        write_clear(4'b0010);
        apply_samples(0, 0, 0, 0);
        write_threshold(1, 0, -2000);
        apply_samples(0, -1500, 0, 0);
        check_bit("trip_low[1]", trip_low[1], 1'b0);
        apply_samples(0, -2500, 0, 0);
        write_clear(4'b0010);
        apply_samples(0, 0, 0, 0);
        write_mask(4'b0000);
    endtask

    task automatic test_status_capture();
        apply_samples(0, 0, 0, 0);
        write_clear(4'b1111);
        idle_cycles(1);
        check_outputs();
        apply_samples(0, 0, 2000, 0);
        check_channel("first_fault_channel", first_fault_channel, channel_index_t'(2));
        apply_samples(-2000, 0, 2000, 0);
        check_mask("status_high", status_high, 4'b0100);
        check_mask("status_low", status_low, 4'b0001);
        check_channel("first_fault_channel", first_fault_channel, channel_index_t'(2));
        apply_samples(0, 0, 0, 0);
        write_clear(4'b1111);
        idle_cycles(1);
        check_outputs();
        check_bit("first_fault_valid", first_fault_valid, 1'b0);
    endtask

    task automatic test_absent_strobes();
        apply_samples(0, 0, 0, -2000);
        // new samples without the strobe must not move any trip
        sample_0 = sample_t'(5000);
        sample_1 = sample_t'(-5000);
        sample_3 = sample_t'(0);
        idle_cycles(3);
        check_trips();
        apply_samples(0, 0, 0, 0);
        write_register(18, 'hf);
        write_register(24, 'h7fff);
        write_register(31, 'hf);
        idle_cycles(1);
        check_outputs();
        // channel 3 still releases, so the latching mask was not touched
        apply_samples(0, 0, 0, -2000);
        apply_samples(0, 0, 0, 0);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        sample_valid = 1'b0;
        sample_0 = '0;
        sample_1 = '0;
        sample_2 = '0;
        sample_3 = '0;
        write_strobe = 1'b0;
        write_address = '0;
        write_data = '0;
        error_count = 0;
        void'($urandom(9416));
        // every register of the DUT comes out of reset at 0
        for (int ch = 0; ch < `PROT_CHANNELS; ch++) begin
            for (int i = 0; i < 4; i++) begin
                model_threshold[ch][i] = '0;
            end
        end
        model_trip_high = '0;
        model_trip_low = '0;
        model_latched = '0;
        model_mask = '0;
        model_status_high = '0;
        model_status_low = '0;
        model_ff_valid = 1'b0;
        model_ff_channel = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;
        test_reset_and_idle();
        test_hysteresis();
        test_random_normal();
        test_latching();
        test_status_capture();
        test_absent_strobes();
        $display("protection testbench finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/protection_pkg.sv
logic/threshold_comparator.sv
logic/protection_registers.sv
logic/fault_collector.sv
logic/protection_top.sv
test/protection_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the protection testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f sources.f --top-module protection_tb -o protection_sim

./obj_dir/protection_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation log is clean"
